//--- design/csr_bus_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "trap_config.svh"

interface csr_bus_if;

    trap_pkg::csr_addr_t addr;
    logic [`XLEN-1:0]    wdata;
    logic                we;
    logic [`XLEN-1:0]    rdata; // combinational read of addr

    modport trap_master (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport csr_slave (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

`default_nettype wire

//--- design/machine_csr.sv
`timescale 1ns/10ps
`default_nettype none
`include "trap_config.svh"

module machine_csr (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire trap_pkg::csr_addr_t csr_addr_i,
    input  wire                 csr_we_i,
    input  wire [`XLEN-1:0]     csr_wdata_i,
    output logic [`XLEN-1:0]    csr_rdata_o,
    output logic                mie_o,
    csr_bus_if.csr_slave        bus
);

    trap_pkg::csr_word_u mstatus_q;
    trap_pkg::csr_word_u wr_word;
    trap_pkg::csr_word_u mstatus_wr;

    logic [`XLEN-1:0]    mepc_q;
    logic [`XLEN-1:0]    mcause_q;
    logic [`XLEN-1:0]    mtval_q;
    logic [`XLEN-1:0]    mtvec_q;

    logic                wr_en;
    trap_pkg::csr_addr_t wr_addr;
    logic [`XLEN-1:0]    wr_data;

    function automatic logic [`XLEN-1:0] read_csr(input trap_pkg::csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS: read_csr = mstatus_q.raw;
            `CSR_MEPC:    read_csr = mepc_q;
            `CSR_MCAUSE:  read_csr = mcause_q;
            `CSR_MTVAL:   read_csr = mtval_q;
            `CSR_MTVEC:   read_csr = mtvec_q;
            default:      read_csr = '0; // unmapped
        endcase
    endfunction

    always_comb begin
        bus.rdata   = read_csr(bus.addr);
        csr_rdata_o = read_csr(csr_addr_i);
    end

    // sequencer write wins, core write is dropped that cycle
    always_comb begin
        wr_en   = bus.we | csr_we_i;
        wr_addr = bus.we ? bus.addr : csr_addr_i;
        wr_data = bus.we ? bus.wdata : csr_wdata_i;
    end

    always_comb begin
        wr_word.raw       = wr_data;
        mstatus_wr.raw    = '0;
        mstatus_wr.f.mie  = wr_word.f.mie; // only mie and mpie are kept
        mstatus_wr.f.mpie = wr_word.f.mpie;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q.raw <= '0;
            mepc_q        <= '0;
            mcause_q      <= '0;
            mtval_q       <= '0;
            mtvec_q       <= `MTVEC_RESET;
        end else if (wr_en) begin
            case (wr_addr)
                `CSR_MSTATUS: mstatus_q <= mstatus_wr;
                `CSR_MEPC:    mepc_q    <= {wr_data[`XLEN-1:2], 2'b00};
                `CSR_MCAUSE:  mcause_q  <= wr_data;
                `CSR_MTVAL:   mtval_q   <= wr_data;
                `CSR_MTVEC:   mtvec_q   <= {wr_data[`XLEN-1:2], 2'b00}; // direct mode
                default: ;
            endcase
        end
    end

    assign mie_o = mstatus_q.f.mie;

    // the sequencer only ever targets the trap CSRs
    a_bus_mapped: assert property (@(posedge clk) disable iff (!rst_n)
        bus.we |-> bus.addr inside {`CSR_MSTATUS, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL})
        else $error("sequencer write to unmapped CSR %h", bus.addr);

endmodule

`default_nettype wire

//--- design/trap_config.svh
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

`define XLEN 32

// machine CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MTVAL   12'h343

`define CAUSE_ECALL      11 // ecall from M-mode
`define CAUSE_EBREAK     3
`define CAUSE_ILLEGAL    2
`define CAUSE_LOAD_FAULT 5

`define IRQ_EXT   11
`define IRQ_TIMER 7
`define IRQ_SOFT  3

`define MTVEC_RESET 32'h0000_0100 // direct mode entry
`endif

//--- design/trap_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "trap_config.svh"

module trap_ctrl (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               ecall_i,
    input  wire               ebreak_i,
    input  wire               inst_err_i,
    input  wire               mem_err_i,
    input  wire               ext_irq_i,
    input  wire               timer_irq_i,
    input  wire               soft_irq_i,
    input  wire               mie_i,
    input  wire               wfi_i,
    input  wire [`XLEN-1:0]   pc_i,
    input  wire [`XLEN-1:0]   inst_i,
    input  wire [`XLEN-1:0]   mem_addr_i,
    input  wire [`XLEN-1:0]   pc_n_i,
    output logic [`XLEN-1:0]  pc_n_o,
    output logic              trap_jump_o,
    output logic              trap_in_o,
    output logic              ext_ack_o,
    output logic              timer_ack_o,
    output logic              soft_ack_o,
    csr_bus_if.trap_master    csr
);

    trap_pkg::trap_state_e state_q;
    trap_pkg::trap_state_e state_d;

    logic             exc_any;
    logic             irq_any;
    logic             trap_det;
    logic             ecall_r;
    logic             ebreak_r;
    logic             inst_err_r;
    logic             mem_err_r;
    logic             exc_r;
    logic             ext_r;
    logic             timer_r;
    logic             soft_r;
    logic [`XLEN-1:0] pc_r;
    logic [`XLEN-1:0] inst_r;
    logic [`XLEN-1:0] mem_addr_r;
    logic [`XLEN-1:0] cause_gen;
    logic [`XLEN-1:0] tval_gen;

    trap_pkg::csr_word_u mstatus_w;

    assign exc_any = ecall_i | ebreak_i | inst_err_i | mem_err_i; // not maskable
    assign irq_any = ext_irq_i | timer_irq_i | soft_irq_i;
    assign trap_det = ((state_q == trap_pkg::IDLE) || (state_q == trap_pkg::SWFI))
                      && (exc_any || (irq_any && mie_i));

    always_comb begin
        case (state_q)
            trap_pkg::IDLE: begin
                if (trap_det)
                    state_d = trap_pkg::CMIE;
                else if (wfi_i)
                    state_d = trap_pkg::SWFI;
                else
                    state_d = trap_pkg::IDLE;
            end
            trap_pkg::SWFI: begin
                if (trap_det)
                    state_d = trap_pkg::CMIE;
                else if (irq_any)
                    state_d = trap_pkg::IDLE; // masked irq wakes the core
                else
                    state_d = trap_pkg::SWFI;
            end
            trap_pkg::CMIE: state_d = trap_pkg::WRPC;
            trap_pkg::WRPC: state_d = trap_pkg::WMCA;
            trap_pkg::WMCA: state_d = trap_pkg::WTVA;
            trap_pkg::WTVA: state_d = trap_pkg::JVPC;
            default:        state_d = trap_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= trap_pkg::IDLE;
            ecall_r    <= 1'b0;
            ebreak_r   <= 1'b0;
            inst_err_r <= 1'b0;
            mem_err_r  <= 1'b0;
            ext_r      <= 1'b0;
            timer_r    <= 1'b0;
            soft_r     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (trap_det) begin // capture the event that was accepted
                ecall_r    <= ecall_i;
                ebreak_r   <= ebreak_i;
                inst_err_r <= inst_err_i;
                mem_err_r  <= mem_err_i;
                ext_r      <= ext_irq_i;
                timer_r    <= timer_irq_i;
                soft_r     <= soft_irq_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap_det) begin
            pc_r       <= pc_i;
            inst_r     <= inst_i;
            mem_addr_r <= mem_addr_i;
        end
    end

    assign exc_r = ecall_r | ebreak_r | inst_err_r | mem_err_r;

    // cause and value, exceptions win over interrupts
    always_comb begin
        cause_gen = '0;
        tval_gen  = '0;
        if (exc_r) begin
            if (inst_err_r) begin
                cause_gen = `XLEN'(`CAUSE_ILLEGAL);
                tval_gen  = inst_r; // offending instruction
            end else if (mem_err_r) begin
                cause_gen = `XLEN'(`CAUSE_LOAD_FAULT);
                tval_gen  = mem_addr_r;
            end else if (ebreak_r) begin
                cause_gen = `XLEN'(`CAUSE_EBREAK);
            end else begin
                cause_gen = `XLEN'(`CAUSE_ECALL);
            end
        end else begin
            if (ext_r)
                cause_gen = `XLEN'(`IRQ_EXT);
            else if (timer_r)
                cause_gen = `XLEN'(`IRQ_TIMER);
            else
                cause_gen = `XLEN'(`IRQ_SOFT);
            cause_gen[`XLEN-1] = 1'b1; // interrupt flag
        end
    end

    always_comb begin
        mstatus_w.raw    = csr.rdata;
        mstatus_w.f.mpie = mstatus_w.f.mie;
        mstatus_w.f.mie  = 1'b0;
    end

    always_comb begin
        csr.addr    = `CSR_MSTATUS;
        csr.wdata   = '0;
        csr.we      = 1'b0;
        trap_jump_o = 1'b0;
        pc_n_o      = pc_n_i;
        case (state_q)
            trap_pkg::CMIE: begin
                csr.wdata = mstatus_w.raw;
                csr.we    = 1'b1;
            end
            trap_pkg::WRPC: begin
                csr.addr  = `CSR_MEPC;
                csr.wdata = pc_r;
                csr.we    = 1'b1;
            end
            trap_pkg::WMCA: begin
                csr.addr  = `CSR_MCAUSE;
                csr.wdata = cause_gen;
                csr.we    = 1'b1;
            end
            trap_pkg::WTVA: begin
                csr.addr  = `CSR_MTVAL;
                csr.wdata = tval_gen;
                csr.we    = 1'b1;
            end
            trap_pkg::JVPC: begin
                csr.addr    = `CSR_MTVEC;
                trap_jump_o = 1'b1;
                pc_n_o      = {csr.rdata[`XLEN-1:2], 2'b00}; // direct mode only
            end
            default: ;
        endcase
    end

    assign trap_in_o   = trap_det || (state_q != trap_pkg::IDLE);
    assign ext_ack_o   = (state_q == trap_pkg::JVPC) && !exc_r && ext_r;
    assign timer_ack_o = (state_q == trap_pkg::JVPC) && !exc_r && !ext_r && timer_r;
    assign soft_ack_o  = (state_q == trap_pkg::JVPC) && !exc_r && !ext_r && !timer_r
                         && soft_r;

    // jump follows the last CSR write and never overlaps one
    a_jump_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        trap_jump_o |-> !csr.we && $past(csr.we))
        else $error("trap jump without a preceding mtval write");

    a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ext_ack_o, timer_ack_o, soft_ack_o}))
        else $error("more than one interrupt ack");

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state_q inside {trap_pkg::IDLE, trap_pkg::SWFI, trap_pkg::CMIE, trap_pkg::WRPC,
                        trap_pkg::WMCA, trap_pkg::WTVA, trap_pkg::JVPC})
        else $error("trap FSM in illegal state");

endmodule

`default_nettype wire

//--- design/trap_pkg.sv
`default_nettype none
`include "trap_config.svh"

package trap_pkg;

    typedef logic [11:0] csr_addr_t;

    typedef enum logic [2:0] {
        IDLE = 3'd0,
        SWFI = 3'd1, // parked by wfi
        CMIE = 3'd2, // mpie <= mie, mie <= 0
        WRPC = 3'd3, // write mepc
        WMCA = 3'd4, // write mcause
        WTVA = 3'd5, // write mtval
        JVPC = 3'd6  // jump to mtvec
    } trap_state_e;

    typedef struct packed {
        logic [`XLEN-1:8] rsvd_hi;
        logic             mpie; // bit 7
        logic [6:4]       rsvd_mid;
        logic             mie;  // bit 3
        logic [2:0]       rsvd_lo;
    } mstatus_t;

    typedef union packed {
        logic [`XLEN-1:0] raw;
        mstatus_t         f;
    } csr_word_u;

endpackage

`default_nettype wire

//--- design/trap_unit_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "trap_config.svh"

module trap_unit_top (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               ecall_i,
    input  wire               ebreak_i,
    input  wire               inst_err_i,
    input  wire               mem_err_i,
    input  wire               ext_irq_i,
    input  wire               timer_irq_i,
    input  wire               soft_irq_i,
    input  wire               wfi_i,
    input  wire [`XLEN-1:0]   pc_i,
    input  wire [`XLEN-1:0]   inst_i,
    input  wire [`XLEN-1:0]   mem_addr_i,
    input  wire [`XLEN-1:0]   pc_n_i,
    output logic [`XLEN-1:0]  pc_n_o,
    output logic              trap_jump_o,
    output logic              trap_in_o,
    output logic              ext_ack_o,
    output logic              timer_ack_o,
    output logic              soft_ack_o,
    input  wire [11:0]        csr_addr_i,
    input  wire               csr_we_i,
    input  wire [`XLEN-1:0]   csr_wdata_i,
    output logic [`XLEN-1:0]  csr_rdata_o
);

    logic mie; // live mstatus.mie

    csr_bus_if csr_bus ();

    trap_ctrl u_trap_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .ecall_i     (ecall_i),
        .ebreak_i    (ebreak_i),
        .inst_err_i  (inst_err_i),
        .mem_err_i   (mem_err_i),
        .ext_irq_i   (ext_irq_i),
        .timer_irq_i (timer_irq_i),
        .soft_irq_i  (soft_irq_i),
        .mie_i       (mie),
        .wfi_i       (wfi_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .mem_addr_i  (mem_addr_i),
        .pc_n_i      (pc_n_i),
        .pc_n_o      (pc_n_o),
        .trap_jump_o (trap_jump_o),
        .trap_in_o   (trap_in_o),
        .ext_ack_o   (ext_ack_o),
        .timer_ack_o (timer_ack_o),
        .soft_ack_o  (soft_ack_o),
        .csr         (csr_bus.trap_master)
    );

    machine_csr u_machine_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_addr_i  (csr_addr_i),
        .csr_we_i    (csr_we_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .mie_o       (mie),
        .bus         (csr_bus.csr_slave)
    );

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/trap_pkg.sv
design/csr_bus_if.sv
design/trap_ctrl.sv
design/machine_csr.sv
design/trap_unit_top.sv
verif/trap_unit_tb.sv

//--- verif/trap_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "trap_config.svh"

module trap_unit_tb;

    localparam int NUM_TESTS  = 6;
    localparam int CLK_PERIOD = 10;

    logic             clk;
    logic             rst_n;
    logic             ecall, ebreak, inst_err, mem_err;
    logic             ext_irq, timer_irq, soft_irq, wfi;
    logic [`XLEN-1:0] pc, inst, mem_addr, pc_n;
    logic [11:0]      csr_addr;
    logic             csr_we;
    logic [`XLEN-1:0] csr_wdata;
    wire  [`XLEN-1:0] pc_n_out;
    wire              trap_jump, trap_in, ext_ack, timer_ack, soft_ack;
    wire  [`XLEN-1:0] csr_rdata;

    logic [31:0]      lfsr_q;
    logic [`XLEN-1:0] mtvec_exp; // expected jump target
    int               err_cnt;
    int               tests_ok;
    int               tests_bad;

    trap_unit_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .ecall_i     (ecall),
        .ebreak_i    (ebreak),
        .inst_err_i  (inst_err),
        .mem_err_i   (mem_err),
        .ext_irq_i   (ext_irq),
        .timer_irq_i (timer_irq),
        .soft_irq_i  (soft_irq),
        .wfi_i       (wfi),
        .pc_i        (pc),
        .inst_i      (inst),
        .mem_addr_i  (mem_addr),
        .pc_n_i      (pc_n),
        .pc_n_o      (pc_n_out),
        .trap_jump_o (trap_jump),
        .trap_in_o   (trap_in),
        .ext_ack_o   (ext_ack),
        .timer_ack_o (timer_ack),
        .soft_ack_o  (soft_ack),
        .csr_addr_i  (csr_addr),
        .csr_we_i    (csr_we),
        .csr_wdata_i (csr_wdata),
        .csr_rdata_o (csr_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic trap_pkg::csr_word_u mstatus_of(input logic mie, input logic mpie);
        trap_pkg::csr_word_u w;
        w.raw    = '0;
        w.f.mie  = mie;
        w.f.mpie = mpie;
        return w;
    endfunction

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_mstatus(input string name, input trap_pkg::csr_word_u exp,
                                 input trap_pkg::csr_word_u act);
        if (act.raw !== exp.raw) begin
            $display("CHECK FAILED t=%0t %s expected %h (mie %b mpie %b) got %h (mie %b mpie %b)",
                     $time, name, exp.raw, exp.f.mie, exp.f.mpie, act.raw, act.f.mie, act.f.mpie);
            err_cnt++;
        end
    endtask

    task automatic check_acks_low();
        check_bit("ext_ack_o", 1'b0, ext_ack);
        check_bit("timer_ack_o", 1'b0, timer_ack);
        check_bit("soft_ack_o", 1'b0, soft_ack);
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [`XLEN-1:0] data);
        @(negedge clk);
        csr_addr  = addr;
        csr_wdata = data;
        csr_we    = 1'b1;
        @(negedge clk);
        csr_we    = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [`XLEN-1:0] data);
        @(negedge clk);
        csr_addr = addr;
        #1;
        data = csr_rdata; // combinational read
    endtask

    task automatic wait_jump(output bit seen, output int cycles);
        cycles = 0;
        while (!trap_jump && cycles < 10) begin
            check_bit("trap_in_o", 1'b1, trap_in);
            check_acks_low();
            @(negedge clk);
            #1;
            cycles++;
        end
        seen = trap_jump;
        if (!seen) begin
            $display("ERROR t=%0t trap jump did not come within 10 cycles", $time);
            err_cnt++;
        end
    endtask

    // ev bits are {ecall, ebreak, illegal, mem fault, ext, timer, soft} held for one cycle
    task automatic take_trap(input logic [6:0] ev, input logic [`XLEN-1:0] epc,
                             input logic [2:0] exp_ack);
        bit seen;
        int cycles;
        @(negedge clk);
        {ecall, ebreak, inst_err, mem_err, ext_irq, timer_irq, soft_irq} = ev;
        pc = epc;
        #1;
        check_bit("trap_in_o", 1'b1, trap_in); // detection cycle
        @(negedge clk);
        {ecall, ebreak, inst_err, mem_err, ext_irq, timer_irq, soft_irq} = '0;
        #1;
        wait_jump(seen, cycles);
        if (seen) begin
            if (cycles != 4) begin
                $display("ERROR t=%0t trap jump came %0d cycles after detection instead of 5",
                         $time, cycles + 1);
                err_cnt++;
            end
            check_bit("trap_in_o", 1'b1, trap_in);
            check_word("pc_n_o", mtvec_exp, pc_n_out);
            check_bit("ext_ack_o", exp_ack[2], ext_ack);
            check_bit("timer_ack_o", exp_ack[1], timer_ack);
            check_bit("soft_ack_o", exp_ack[0], soft_ack);
        end
        @(negedge clk);
        #1;
        check_bit("trap_in_o", 1'b0, trap_in);
        check_bit("trap_jump_o", 1'b0, trap_jump);
        check_word("pc_n_o", pc_n, pc_n_out); // pass-through again
        check_acks_low(); // acks last one cycle
    endtask

    task automatic check_trap(input logic [`XLEN-1:0] mepc, input logic [`XLEN-1:0] cause,
                              input logic [`XLEN-1:0] tval, input trap_pkg::csr_word_u status);
        logic [`XLEN-1:0]    rd;
        trap_pkg::csr_word_u st;
        csr_read(`CSR_MEPC, rd);
        check_word("mepc", mepc, rd);
        csr_read(`CSR_MCAUSE, rd);
        check_word("mcause", cause, rd);
        csr_read(`CSR_MTVAL, rd);
        check_word("mtval", tval, rd);
        csr_read(`CSR_MSTATUS, st.raw);
        check_mstatus("mstatus", status, st);
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_before);
            tests_bad++;
        end
    endtask

    task automatic test_ecall();
        int                  e0;
        logic [`XLEN-1:0]    rd;
        trap_pkg::csr_word_u st;
        e0 = err_cnt;
        csr_read(`CSR_MTVEC, rd);
        check_word("mtvec", `MTVEC_RESET, rd); // reset values
        csr_read(`CSR_MSTATUS, st.raw);
        check_mstatus("mstatus", mstatus_of(1'b0, 1'b0), st);
        mtvec_exp = 32'h0000_4000;
        csr_write(`CSR_MTVEC, 32'h0000_4003); // low bits must drop
        csr_read(`CSR_MTVEC, rd);
        check_word("mtvec", mtvec_exp, rd);
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        check_word("pc_n_o", pc_n, pc_n_out);
        take_trap(7'b1000000, 32'h0000_1230, 3'b000);
        check_trap(32'h0000_1230, `CAUSE_ECALL, '0, mstatus_of(1'b0, 1'b1));
        report("ecall", e0);
    endtask

    task automatic test_exc_kinds();
        int e0;
        e0 = err_cnt;
        @(negedge clk);
        inst     = 32'hdead_beef;
        mem_addr = 32'h0000_8abc;
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        take_trap(7'b0011000, 32'h0000_2000, 3'b000); // illegal beats fault
        check_trap(32'h0000_2000, `CAUSE_ILLEGAL, 32'hdead_beef, mstatus_of(1'b0, 1'b1));
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        take_trap(7'b0001000, 32'h0000_2010, 3'b000);
        check_trap(32'h0000_2010, `CAUSE_LOAD_FAULT, 32'h0000_8abc, mstatus_of(1'b0, 1'b1));
        report("illegal and memory fault", e0);
    endtask

    task automatic test_irq_priority();
        int e0;
        e0 = err_cnt;
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        take_trap(7'b0000111, 32'h0000_3100, 3'b100);
        check_trap(32'h0000_3100, 32'h8000_000b, '0, mstatus_of(1'b0, 1'b1));
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        take_trap(7'b0000010, 32'h0000_3104, 3'b010);
        check_trap(32'h0000_3104, 32'h8000_0007, '0, mstatus_of(1'b0, 1'b1));
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        take_trap(7'b0000001, 32'h0000_3108, 3'b001);
        check_trap(32'h0000_3108, 32'h8000_0003, '0, mstatus_of(1'b0, 1'b1));
        report("interrupt priority", e0);
    endtask

    task automatic test_masking();
        int e0;
        e0 = err_cnt;
        csr_write(`CSR_MSTATUS, 32'h0000_0000);
        @(negedge clk);
        timer_irq = 1'b1;
        repeat (10) begin
            #1;
            check_bit("trap_in_o", 1'b0, trap_in);
            check_bit("trap_jump_o", 1'b0, trap_jump);
            @(negedge clk);
        end
        timer_irq = 1'b0;
        take_trap(7'b0100000, 32'h0000_3000, 3'b000); // exceptions ignore mie
        check_trap(32'h0000_3000, `CAUSE_EBREAK, '0, mstatus_of(1'b0, 1'b0));
        report("masking", e0);
    endtask

    task automatic test_wfi();
        int e0;
        e0 = err_cnt;
        csr_write(`CSR_MSTATUS, 32'h0000_0008);
        @(negedge clk);
        wfi = 1'b1;
        @(negedge clk);
        wfi = 1'b0;
        repeat (3) begin
            #1;
            check_bit("trap_in_o", 1'b1, trap_in); // parked
            @(negedge clk);
        end
        take_trap(7'b0000010, 32'h0000_4440, 3'b010);
        check_trap(32'h0000_4440, 32'h8000_0007, '0, mstatus_of(1'b0, 1'b1));
        csr_write(`CSR_MSTATUS, 32'h0000_0000);
        @(negedge clk);
        wfi = 1'b1;
        @(negedge clk);
        wfi = 1'b0;
        #1;
        check_bit("trap_in_o", 1'b1, trap_in);
        @(negedge clk);
        timer_irq = 1'b1; // masked wake-up
        #1;
        check_bit("trap_in_o", 1'b1, trap_in);
        @(negedge clk);
        timer_irq = 1'b0;
        repeat (5) begin
            #1;
            check_bit("trap_in_o", 1'b0, trap_in);
            check_bit("trap_jump_o", 1'b0, trap_jump);
            @(negedge clk);
        end
        report("wfi", e0);
    endtask

    task automatic test_random();
        int               e0;
        logic [1:0]       kind;
        logic [`XLEN-1:0] epc;
        logic [`XLEN-1:0] cause;
        logic [`XLEN-1:0] tval;
        e0 = err_cnt;
        for (int r = 0; r < 20; r++) begin
            @(negedge clk);
            kind     = 2'(take_bits(2)); // 0 ecall, 1 ebreak, 2 illegal, 3 fault
            epc      = take_bits(32);
            inst     = take_bits(32);
            mem_addr = take_bits(32);
            case (kind)
                2'd0:    cause = `CAUSE_ECALL;
                2'd1:    cause = `CAUSE_EBREAK;
                2'd2:    cause = `CAUSE_ILLEGAL;
                default: cause = `CAUSE_LOAD_FAULT;
            endcase
            tval = (kind == 2'd2) ? inst : ((kind == 2'd3) ? mem_addr : '0);
            csr_write(`CSR_MSTATUS, 32'h0000_0008);
            take_trap(7'b1000000 >> kind, epc, 3'b000);
            check_trap({epc[`XLEN-1:2], 2'b00}, cause, tval, mstatus_of(1'b0, 1'b1));
        end
        report("random traps", e0);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        {ecall, ebreak, inst_err, mem_err} = '0;
        {ext_irq, timer_irq, soft_irq, wfi} = '0;
        pc        = '0;
        inst      = '0;
        mem_addr  = '0;
        pc_n      = 32'h0000_2004;
        csr_addr  = '0;
        csr_we    = 1'b0;
        csr_wdata = '0;
        lfsr_q    = 32'hb2039be7;
        mtvec_exp = `MTVEC_RESET;
        err_cnt   = 0;
        tests_ok  = 0;
        tests_bad = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_bit("trap_in_o", 1'b0, trap_in);
        check_bit("trap_jump_o", 1'b0, trap_jump);
        check_acks_low();
        test_ecall();
        test_exc_kinds();
        test_irq_priority();
        test_masking();
        test_wfi();
        test_random();
        $display("summary: %0d tests ok, %0d tests with errors, %0d check errors",
                 tests_ok, tests_bad, err_cnt);
        if (tests_bad == 0 && err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog: run did not end within %0d cycles", NUM_TESTS * 200);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
